/* vlog.f */
isa_pkg.sv
bpred_pkg.sv
fu_branch_if.sv
btb_update_if.sv
fu_branch.sv
btb.sv
branch_unit_top.sv
tb_branch_unit.sv

/* tb_branch_unit.sv */
`timescale 1ns/1ps

module tb_branch_unit;
  import isa_pkg::*;
  import bpred_pkg::*;

  localparam int CLK_PERIOD    = 20;
  localparam int RESET_CYCLES  = 8;
  localparam int RAND_PER_TYPE = 24;
  localparam int FORCED        = 5;
  // Cycles per test for reset, after-reset, branches, jumps, counter, single update and aliasing
  localparam int TEST_CYCLES = RESET_CYCLES + 4 + 6 * (RAND_PER_TYPE + FORCED) + 1 + 8
                               + 14 + 10 + 6;
  localparam int WATCHDOG_CYCLES = TEST_CYCLES + 100;

  logic         CLK;
  logic         nRST;
  logic         enable;
  jump_type_t   j_type;
  branch_type_t branch_type;
  word_t        reg_a;
  word_t        reg_b;
  word_t        imm;
  word_t        current_pc;
  logic         predicted_outcome;
  logic         resolved;
  logic         branch_outcome;
  logic         miss;
  word_t        correct_pc;
  word_t        branch_target;
  word_t        jump_wdat;
  word_t        lookup_pc;
  logic         pred_hit;
  logic         pred_taken;
  word_t        pred_target;

  // Expected values for the cycle being checked
  logic       chk_on;
  logic       exp_en;
  jump_type_t exp_jt;
  logic       exp_taken;
  logic       exp_miss;
  word_t      exp_npc;
  word_t      exp_tgt;
  word_t      exp_wdat;
  logic       exp_hit;
  counter_t   exp_cnt;
  word_t      exp_lk_tgt;

  // BTB model keyed by index
  logic [BTB_TAG_W-1:0] mdl_tag    [int];
  word_t                mdl_target [int];
  int                   mdl_cnt    [int];

  // Training strobe of the cycle in flight that is committed at the next edge
  logic  pend_upd = 1'b0;
  word_t pend_pc;
  word_t pend_tgt;
  logic  pend_taken;
  logic  prev_branch = 1'b0;
  word_t prev_pc;

  int    errors = 0;
  int    checks = 0;
  int    tests_run = 0;
  int    test_start = 0;
  string test_name;

  branch_unit_top i_dut (
    .CLK               (CLK),
    .nRST              (nRST),
    .enable            (enable),
    .j_type            (j_type),
    .branch_type       (branch_type),
    .reg_a             (reg_a),
    .reg_b             (reg_b),
    .imm               (imm),
    .current_pc        (current_pc),
    .predicted_outcome (predicted_outcome),
    .resolved          (resolved),
    .branch_outcome    (branch_outcome),
    .miss              (miss),
    .correct_pc        (correct_pc),
    .branch_target     (branch_target),
    .jump_wdat         (jump_wdat),
    .lookup_pc         (lookup_pc),
    .pred_hit          (pred_hit),
    .pred_taken        (pred_taken),
    .pred_target       (pred_target)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Expected next PC with the branch direction returned through taken
  function automatic word_t ref_resolve(input jump_type_t jt, input branch_type_t bt,
                                        input word_t a, input word_t b, input word_t im,
                                        input word_t pc, output logic taken);
    logic lt_s;
    logic lt_u;
    // Flipping the sign bit turns a signed compare into an unsigned one
    lt_s  = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    lt_u  = a < b;
    taken = 1'b0;
    if (jt == JT_JAL) return pc + im;
    if (jt == JT_JALR) return (a + im) & 32'hffff_fffe;
    case (bt)
      BT_BEQ:  taken = (a == b);
      BT_BNE:  taken = (a != b);
      BT_BLT:  taken = lt_s;
      BT_BGE:  taken = !lt_s;
      BT_BLTU: taken = lt_u;
      BT_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
    return taken ? pc + im : pc + 32'd4;
  endfunction

  task automatic check_word(input string name, input word_t exp, input word_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error %s: expected 0x%h, got 0x%h", name, exp, got);
    end
  endtask

  task automatic check_pred(input string name, input logic hit, input counter_t cnt,
                            input logic got);
    logic exp;
    checks++;
    exp = hit && (cnt >= CNT_WEAK_T);
    if (got !== exp) begin
      errors++;
      $display("error %s: expected 0x%h, got 0x%h (counter %s)", name, exp, got, cnt.name());
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (chk_on) begin
      check_bit("resolved", exp_en, resolved);
      check_bit("miss", exp_miss, miss);
      if (exp_en && exp_jt == JT_BRANCH) begin
        check_bit("branch_outcome", exp_taken, branch_outcome);
        check_word("correct_pc", exp_npc, correct_pc);
        check_word("branch_target", exp_tgt, branch_target);
      end else if (exp_en) begin
        check_word("jump_wdat", exp_wdat, jump_wdat);
        check_word("correct_pc", exp_npc, correct_pc);
      end
      check_bit("pred_hit", exp_hit, pred_hit);
      check_pred("pred_taken", exp_hit, exp_cnt, pred_taken);
      check_word("pred_target", exp_lk_tgt, pred_target);
    end
  end

  task automatic commit_update();
    int                   idx;
    logic [BTB_TAG_W-1:0] tag;
    if (pend_upd) begin
      idx = pend_pc[BTB_IDX_LSB +: BTB_IDX_W];
      tag = pend_pc[31 -: BTB_TAG_W];
      if (mdl_tag.exists(idx) && mdl_tag[idx] == tag) begin
        if (pend_taken && mdl_cnt[idx] < 3) mdl_cnt[idx] = mdl_cnt[idx] + 1;
        else if (!pend_taken && mdl_cnt[idx] > 0) mdl_cnt[idx] = mdl_cnt[idx] - 1;
      end else begin
        mdl_tag[idx] = tag;
        mdl_cnt[idx] = pend_taken ? 2 : 1;
      end
      mdl_target[idx] = pend_tgt;
      pend_upd = 1'b0;
    end
  endtask

  task automatic issue_cycle(input logic en, input jump_type_t jt, input branch_type_t bt,
                             input word_t a, input word_t b, input word_t im, input word_t pc,
                             input logic pred, input word_t lk);
    logic  tk;
    logic  is_br;
    word_t npc;
    int    idx;
    @(posedge CLK);
    commit_update();
    npc   = ref_resolve(jt, bt, a, b, im, pc, tk);
    is_br = en && (jt == JT_BRANCH);
    enable            <= en;
    j_type            <= jt;
    branch_type       <= bt;
    reg_a             <= a;
    reg_b             <= b;
    imm               <= im;
    current_pc        <= pc;
    predicted_outcome <= pred;
    lookup_pc         <= lk;
    exp_en    <= en;
    exp_jt    <= jt;
    exp_taken <= tk;
    exp_npc   <= npc;
    exp_tgt   <= pc + im;
    exp_wdat  <= npc;
    exp_miss  <= is_br && (tk != pred);
    // Lookup sees the BTB before this cycle's own training
    idx = lk[BTB_IDX_LSB +: BTB_IDX_W];
    if (mdl_tag.exists(idx) && mdl_tag[idx] == lk[31 -: BTB_TAG_W]) begin
      exp_hit    <= 1'b1;
      exp_cnt    <= counter_t'(mdl_cnt[idx]);
      exp_lk_tgt <= mdl_target[idx];
    end else begin
      exp_hit    <= 1'b0;
      exp_cnt    <= CNT_STRONG_NT;
      exp_lk_tgt <= '0;
    end
    chk_on <= 1'b1;
    // One training per branch while the same PC stays enabled
    pend_upd    = is_br && !(prev_branch && pc == prev_pc);
    pend_pc     = pc;
    pend_tgt    = pc + im;
    pend_taken  = tk;
    prev_branch = is_br;
    prev_pc     = pc;
  endtask

  task automatic resolve_branch(input branch_type_t bt, input word_t a, input word_t b,
                                input word_t im, input word_t pc, input logic pred);
    issue_cycle(1'b1, JT_BRANCH, bt, a, b, im, pc, pred, pc);
  endtask

  task automatic idle_lookup(input word_t lk);
    issue_cycle(1'b0, JT_BRANCH, BT_BEQ, '0, '0, '0, '0, 1'b0, lk);
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    test_start = errors;
  endtask

  task automatic end_test();
    int n;
    @(negedge CLK);
    #1;
    n = errors - test_start;
    tests_run++;
    $display("test %0d %s: %s (%0d errors)", tests_run, test_name,
             n == 0 ? "ok" : "mismatch", n);
  endtask

  function automatic word_t rand_pc();
    word_t r;
    r = $urandom();
    return {r[31:2], 2'b00};
  endfunction

  // Even, sign-extended 13-bit branch offset
  function automatic word_t rand_imm();
    word_t r;
    r = $urandom();
    return {{19{r[12]}}, r[12:1], 1'b0};
  endfunction

  function automatic branch_type_t type_at(input int t);
    case (t)
      0:       return BT_BEQ;
      1:       return BT_BNE;
      2:       return BT_BLT;
      3:       return BT_BGE;
      4:       return BT_BLTU;
      default: return BT_BGEU;
    endcase
  endfunction

  task automatic test_branches();
    word_t a;
    word_t b;
    word_t pc;
    word_t last_pc;
    last_pc = '0;
    for (int t = 0; t < 6; t++) begin
      for (int i = 0; i < FORCED + RAND_PER_TYPE; i++) begin
        a  = $urandom();
        b  = $urandom();
        pc = rand_pc();
        case (i)
          0: b = a;
          1: begin
            a = 32'hffff_fff0;
            b = 32'd5;
          end
          2: begin
            a = 32'd5;
            b = 32'hffff_fff0;
          end
          3: begin
            a = 32'h7fff_ffff;
            b = 32'h8000_0000;
          end
          4: begin
            a = 32'hffff_ffff;
            b = 32'h0;
          end
          default: ;
        endcase
        // Look up the branch of the cycle before, so back-to-back training shows
        issue_cycle(1'b1, JT_BRANCH, type_at(t), a, b, rand_imm(), pc, $urandom() & 1,
                    last_pc);
        last_pc = pc;
      end
    end
    idle_lookup(last_pc);
  endtask

  initial begin
    // Single seed for the whole run
    void'($urandom(32'hfe52));
    nRST              <= 1'b0;
    enable            <= 1'b0;
    j_type            <= JT_BRANCH;
    branch_type       <= BT_BEQ;
    reg_a             <= '0;
    reg_b             <= '0;
    imm               <= '0;
    current_pc        <= '0;
    predicted_outcome <= 1'b0;
    lookup_pc         <= '0;
    chk_on            <= 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    nRST <= 1'b1;

    start_test("after reset");
    idle_lookup(32'h0000_0000);
    idle_lookup(32'h0000_0044);
    idle_lookup(32'h1234_5678);
    idle_lookup(32'hffff_fffc);
    end_test();

    start_test("branch resolution");
    test_branches();
    end_test();

    start_test("jal and jalr");
    issue_cycle(1'b1, JT_JAL, BT_BEQ, '0, '0, rand_imm(), 32'h0000_1000, 1'b0, 32'h0);
    issue_cycle(1'b1, JT_JALR, BT_BEQ, 32'h2001, '0, 32'h10, 32'h0000_1004, 1'b0, 32'h0);
    issue_cycle(1'b1, JT_JALR, BT_BEQ, $urandom(), '0, $urandom(), 32'h0000_1008, 1'b0, 32'h0);
    issue_cycle(1'b1, JT_JALR, BT_BEQ, 32'h2000, '0, 32'h7, 32'h0000_100c, 1'b0, 32'h0);
    idle_lookup(32'h0000_1000);
    idle_lookup(32'h0000_1004);
    idle_lookup(32'h0000_100c);
    end_test();

    start_test("counter training");
    // A new offset on every hit makes the stored target change
    for (int i = 0; i < 4; i++) begin
      resolve_branch(BT_BEQ, 32'd7, 32'd7, 32'h100 + 16 * i, 32'h0004_0040,
                     $urandom() & 1);
      idle_lookup(32'h0004_0040);
    end
    for (int i = 0; i < 3; i++) begin
      resolve_branch(BT_BNE, 32'd7, 32'd7, 32'h100, 32'h0004_0040, $urandom() & 1);
      idle_lookup(32'h0004_0040);
    end
    end_test();

    start_test("single update");
    // Allocate weak not-taken so a held taken branch can only reach weak taken
    resolve_branch(BT_BNE, 32'd3, 32'd3, 32'h40, 32'h0008_0044, 1'b0);
    idle_lookup(32'h0008_0044);
    repeat (5) resolve_branch(BT_BEQ, 32'd3, 32'd3, 32'h40, 32'h0008_0044, 1'b1);
    idle_lookup(32'h0008_0044);
    resolve_branch(BT_BNE, 32'd3, 32'd3, 32'h40, 32'h0008_0044, 1'b1);
    idle_lookup(32'h0008_0044);
    end_test();

    start_test("aliasing");
    resolve_branch(BT_BLTU, 32'd1, 32'd2, 32'h80, 32'h0010_0048, 1'b1);
    idle_lookup(32'h0010_0048);
    resolve_branch(BT_BLTU, 32'd2, 32'd1, 32'h80, 32'h0020_0048, 1'b0);
    idle_lookup(32'h0020_0048);
    idle_lookup(32'h0010_0048);
    end_test();

    $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
    $display("Checks failed");
    $finish;
  end

endmodule

/* branch_unit_top.sv */
`timescale 1ns/1ps

module branch_unit_top (
  input  logic                   CLK,
  input  logic                   nRST,

  // Issue
  input  logic                   enable,
  input  isa_pkg::jump_type_t    j_type,
  input  isa_pkg::branch_type_t  branch_type,
  input  isa_pkg::word_t         reg_a,
  input  isa_pkg::word_t         reg_b,
  input  isa_pkg::word_t         imm,
  input  isa_pkg::word_t         current_pc,
  input  logic                   predicted_outcome,

  // Resolution
  output logic                   resolved,
  output logic                   branch_outcome,
  output logic                   miss,
  output isa_pkg::word_t         correct_pc,
  output isa_pkg::word_t         branch_target,
  output isa_pkg::word_t         jump_wdat,

  // Fetch lookup
  input  isa_pkg::word_t         lookup_pc,
  output logic                   pred_hit,
  output logic                   pred_taken,
  output isa_pkg::word_t         pred_target
);

  fu_branch_if  fubif ();
  btb_update_if updif ();

  // The top level acts as the issue side
  assign fubif.enable            = enable;
  assign fubif.j_type            = j_type;
  assign fubif.branch_type       = branch_type;
  assign fubif.reg_a             = reg_a;
  assign fubif.reg_b             = reg_b;
  assign fubif.imm               = imm;
  assign fubif.current_pc        = current_pc;
  assign fubif.predicted_outcome = predicted_outcome;

  assign resolved       = fubif.resolved;
  assign branch_outcome = fubif.branch_outcome;
  assign miss           = fubif.miss;
  assign correct_pc     = fubif.correct_pc;
  assign branch_target  = fubif.branch_target;
  assign jump_wdat      = fubif.jump_wdat;

  fu_branch i_fu_branch (
    .CLK   (CLK),
    .nRST  (nRST),
    .fubif (fubif.br),
    .updif (updif.src)
  );

  // Trained by the branch unit, read by fetch
  btb i_btb (
    .CLK         (CLK),
    .nRST        (nRST),
    .updif       (updif.dst),
    .lookup_pc   (lookup_pc),
    .pred_hit    (pred_hit),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

endmodule

/* btb.sv */
`timescale 1ns/1ps

module btb (
  input  logic           CLK,
  input  logic           nRST,
  btb_update_if.dst      updif,
  input  isa_pkg::word_t lookup_pc,
  output logic           pred_hit,
  output logic           pred_taken,
  output isa_pkg::word_t pred_target
);
  import bpred_pkg::*;

  btb_entry_t entries [BTB_ENTRIES];

  // Fetch lookup
  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_TAG_W-1:0] rd_tag;
  btb_entry_t           rd_entry;

  // Training path
  logic [BTB_IDX_W-1:0] wr_idx;
  logic [BTB_TAG_W-1:0] wr_tag;
  btb_entry_t           wr_old;
  btb_entry_t           wr_new;
  logic                 wr_match;

  // Saturating step toward the resolved direction
  function automatic counter_t step_counter(counter_t cur, logic outcome);
    counter_t nxt;
    case (cur)
      CNT_STRONG_NT: nxt = outcome ? CNT_WEAK_NT  : CNT_STRONG_NT;
      CNT_WEAK_NT:   nxt = outcome ? CNT_WEAK_T   : CNT_STRONG_NT;
      CNT_WEAK_T:    nxt = outcome ? CNT_STRONG_T : CNT_WEAK_NT;
      CNT_STRONG_T:  nxt = outcome ? CNT_STRONG_T : CNT_WEAK_T;
      default:       nxt = CNT_WEAK_NT;
    endcase
    return nxt;
  endfunction

  function automatic logic counter_taken(counter_t cnt);
    return (cnt == CNT_WEAK_T) || (cnt == CNT_STRONG_T);
  endfunction

  assign rd_idx   = lookup_pc[BTB_IDX_LSB +: BTB_IDX_W];
  assign rd_tag   = lookup_pc[BTB_IDX_LSB + BTB_IDX_W +: BTB_TAG_W];
  assign rd_entry = entries[rd_idx];

  assign pred_hit    = rd_entry.valid && (rd_entry.tag == rd_tag);
  assign pred_taken  = pred_hit && counter_taken(rd_entry.counter);
  assign pred_target = pred_hit ? rd_entry.target : '0;

  assign wr_idx   = updif.update_pc[BTB_IDX_LSB +: BTB_IDX_W];
  assign wr_tag   = updif.update_pc[BTB_IDX_LSB + BTB_IDX_W +: BTB_TAG_W];
  assign wr_old   = entries[wr_idx];
  assign wr_match = wr_old.valid && (wr_old.tag == wr_tag);

  always_comb begin : next_entry
    wr_new = wr_old;
    if (wr_match) begin
      wr_new.counter = step_counter(wr_old.counter, updif.branch_outcome);
      wr_new.target  = updif.branch_target;
    end else begin
      // Allocate, replacing whatever branch aliased to this index
      wr_new.valid   = 1'b1;
      wr_new.tag     = wr_tag;
      wr_new.target  = updif.branch_target;
      wr_new.counter = updif.branch_outcome ? CNT_WEAK_T : CNT_WEAK_NT;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < BTB_ENTRIES; i++) begin
        entries[i] <= '0;
      end
    end else if (updif.update_btb) begin
      entries[wr_idx] <= wr_new;
    end
  end

endmodule

/* fu_branch.sv */
`timescale 1ns/1ps

module fu_branch (
  input logic        CLK,
  input logic        nRST,
  fu_branch_if.br    fubif,
  btb_update_if.src  updif
);
  import isa_pkg::*;

  logic  cmp_eq;
  logic  cmp_lt;
  logic  cmp_ltu;
  logic  taken;
  logic  is_branch;
  word_t pc_seq;
  word_t pc_rel;
  word_t jalr_dest;

  // Training history for the single-update rule
  logic  btb_updated;
  word_t last_branch_pc;

  // The immediate arrives already decoded and sign-extended
  assign pc_seq    = fubif.current_pc + word_t'(PC_STEP);
  assign pc_rel    = fubif.current_pc + fubif.imm;
  assign jalr_dest = (fubif.reg_a + fubif.imm) & ~word_t'(1);

  assign is_branch = fubif.enable && (fubif.j_type == JT_BRANCH);

  assign cmp_eq  = (fubif.reg_a == fubif.reg_b);
  assign cmp_lt  = ($signed(fubif.reg_a) < $signed(fubif.reg_b));
  assign cmp_ltu = (fubif.reg_a < fubif.reg_b);

  always_comb begin : direction
    case (fubif.branch_type)
      BT_BEQ:  taken = cmp_eq;
      BT_BNE:  taken = ~cmp_eq;
      BT_BLT:  taken = cmp_lt;
      BT_BGE:  taken = ~cmp_lt;
      BT_BLTU: taken = cmp_ltu;
      BT_BGEU: taken = ~cmp_ltu;
      default: taken = 1'b0;
    endcase
  end

  always_comb begin : resolve
    fubif.resolved       = 1'b0;
    fubif.branch_outcome = 1'b0;
    fubif.miss           = 1'b0;
    fubif.correct_pc     = pc_seq;
    fubif.branch_target  = '0;
    fubif.jump_wdat      = '0;

    if (fubif.enable) begin
      case (fubif.j_type)
        JT_BRANCH: begin
          fubif.resolved       = 1'b1;
          fubif.branch_outcome = taken;
          fubif.branch_target  = pc_rel;
          fubif.correct_pc     = taken ? pc_rel : pc_seq;
          fubif.miss           = (taken != fubif.predicted_outcome);
        end
        JT_JAL: begin
          fubif.resolved   = 1'b1;
          fubif.jump_wdat  = pc_rel;
          fubif.correct_pc = pc_rel;
        end
        JT_JALR: begin
          fubif.resolved   = 1'b1;
          fubif.jump_wdat  = jalr_dest;
          fubif.correct_pc = jalr_dest;
        end
        default: begin
          fubif.resolved = 1'b0;
        end
      endcase
    end
  end

  // Remember which branch PC has already trained the BTB
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      btb_updated    <= 1'b0;
      last_branch_pc <= '0;
    end else begin
      if (is_branch) begin
        btb_updated    <= 1'b1;
        last_branch_pc <= fubif.current_pc;
      end else begin
        // Any idle or jump cycle ends the held branch
        btb_updated <= 1'b0;
      end
    end
  end

  // A new PC trains even if the previous branch was held right before it
  assign updif.update_btb = is_branch &&
                            (!btb_updated || (fubif.current_pc != last_branch_pc));

  assign updif.update_pc      = fubif.current_pc;
  assign updif.branch_target  = pc_rel;
  assign updif.branch_outcome = taken;

endmodule

/* btb_update_if.sv */
`timescale 1ns/1ps

interface btb_update_if;
  import isa_pkg::*;

  // Single-cycle training strobe, BTB always accepts
  logic  update_btb;
  word_t update_pc;
  word_t branch_target;
  logic  branch_outcome;

  modport src (
    output update_btb, update_pc, branch_target, branch_outcome
  );

  modport dst (
    input update_btb, update_pc, branch_target, branch_outcome
  );

endinterface

/* fu_branch_if.sv */
`timescale 1ns/1ps

interface fu_branch_if;
  import isa_pkg::*;

  // Issue side
  logic         enable;
  jump_type_t   j_type;
  branch_type_t branch_type;
  word_t        reg_a;
  word_t        reg_b;
  word_t        imm;
  word_t        current_pc;
  logic         predicted_outcome;

  // Resolution results
  logic         resolved;
  logic         branch_outcome;
  logic         miss;
  word_t        correct_pc;
  word_t        branch_target;
  word_t        jump_wdat;

  modport br (
    input  enable, j_type, branch_type,
    input  reg_a, reg_b, imm, current_pc,
    input  predicted_outcome,
    output resolved, branch_outcome, miss,
    output correct_pc, branch_target, jump_wdat
  );

  modport issue (
    output enable, j_type, branch_type,
    output reg_a, reg_b, imm, current_pc,
    output predicted_outcome,
    input  resolved, branch_outcome, miss,
    input  correct_pc, branch_target, jump_wdat
  );

endinterface

/* bpred_pkg.sv */
package bpred_pkg;

  // BTB geometry
  localparam int BTB_ENTRIES = 16;
  localparam int BTB_IDX_W   = 4;
  localparam int BTB_TAG_W   = 26;

  // Word-aligned PCs, so the index starts above the byte offset
  localparam int BTB_IDX_LSB = 2;

  // Two-bit saturating direction counter
  typedef enum logic [1:0] {
    CNT_STRONG_NT = 2'd0,
    CNT_WEAK_NT   = 2'd1,
    CNT_WEAK_T    = 2'd2,
    CNT_STRONG_T  = 2'd3
  } counter_t;

  // One BTB line
  typedef struct packed {
    logic                 valid;
    logic [BTB_TAG_W-1:0] tag;
    isa_pkg::word_t       target;
    counter_t             counter;
  } btb_entry_t;

endpackage

/* isa_pkg.sv */
package isa_pkg;

  // Machine word width for RV32
  localparam int WORD_W = 32;

  // Sequential PC step, no compressed instructions
  localparam int PC_STEP = 4;

  typedef logic [WORD_W-1:0] word_t;

  // Conditional branch kinds, encoded as funct3
  typedef enum logic [2:0] {
    BT_BEQ  = 3'b000,
    BT_BNE  = 3'b001,
    BT_BLT  = 3'b100,
    BT_BGE  = 3'b101,
    BT_BLTU = 3'b110,
    BT_BGEU = 3'b111
  } branch_type_t;

  // Control-transfer class of the issued instruction
  typedef enum logic [1:0] {
    JT_BRANCH = 2'd0,
    JT_JAL    = 2'd1,
    JT_JALR   = 2'd2
  } jump_type_t;

endpackage
